// ==== Bender.yml ====
package:
  name: dataPath

sources:
  - hw/dataPathPkg.sv
  - hw/busMux.sv
  - hw/registerFile.sv
  - hw/specialRegisters.sv
  - hw/aluStage.sv
  - hw/dataPath.sv
  - target: test
    files:
      - testbench/dataPathTb.sv

// ==== compile.f ====
hw/dataPathPkg.sv
hw/busMux.sv
hw/registerFile.sv
hw/specialRegisters.sv
hw/aluStage.sv
hw/dataPath.sv
testbench/dataPathTb.sv

// ==== hw/aluStage.sv ====
`timescale 1ns/10ps

module aluStage import dataPathPkg::*; (
	input logic Clock,
	input logic reset,
	input logic yIn,
	input logic zIn,
	input aluOpT op,
	input wordT bus,
	output wordT yValue,
	output wordT zHighValue,
	output wordT zLowValue
);

	wordT y;
	wordT zHigh;
	wordT zLow;
	wordT aluLow;
	logic [2*wordWidth-1:0] result; // full Z width
	logic [2*wordWidth-1:0] yTwice; // y repeated, for rotates
	shiftAmountT amount;

	assign amount = bus[shiftWidth-1:0]; // distance from the low bits of B
	assign yTwice = {y, y};

	always_comb begin
		case (op)
			opAdd: aluLow = y + bus; // wraps, no carry out
			opSub: aluLow = y - bus;
			opAnd: aluLow = y & bus;
			opOr: aluLow = y | bus;
			opShl: aluLow = y << amount;
			opShr: aluLow = y >> amount;
			opShra: aluLow = wordT'($signed(y) >>> amount);
			opRor: aluLow = yTwice[wordWidth-1:0] >> amount | y << (wordWidth - amount);
			opRol: aluLow = wordT'((yTwice << amount) >> wordWidth);
			opNeg: aluLow = wordT'(0) - bus; // operand A unused
			opNot: aluLow = ~bus;
			default: aluLow = '0;
		endcase
	end

	// no multiply here, so the high half is always zero
	assign result = {wordT'(0), aluLow};

	always_ff @(posedge Clock) begin
		if (reset) begin
			y <= '0;
			zHigh <= '0;
			zLow <= '0;
		end else begin
			if (yIn) y <= bus;
			if (zIn) {zHigh, zLow} <= result;
		end
	end

	assign yValue = y;
	assign zHighValue = zHigh;
	assign zLowValue = zLow;

	// an undefined opcode would silently load zero into Z
	assert property (@(posedge Clock) disable iff (reset)
		zIn |-> !$isunknown(op) && op inside {[opAdd:opNot]})
		else $error("aluStage: undefined opcode %0d with zIn", op);

endmodule

// ==== hw/busMux.sv ====
`timescale 1ns/10ps

module busMux import dataPathPkg::*; (
	input logic Clock,
	input logic reset,
	input outStrobesT outSel,
	input wordT [regCount-1:0] regValues,
	input wordT hiValue,
	input wordT loValue,
	input wordT zHighValue,
	input wordT zLowValue,
	input wordT pcValue,
	input wordT mdrValue,
	input wordT inPortValue,
	input wordT yValue,
	output wordT bus
);

	logic [busSourceCount-1:0] selBits; // flat view of the strobes
	wordT [busSourceCount-1:0] sources;
	logic [busSelWidth-1:0] srcIndex;
	logic srcValid;

	assign selBits = outSel;

	// same order as the strobe struct, so sources[k] belongs to selBits[k]
	assign sources = {regValues, hiValue, loValue, zHighValue, zLowValue,
		pcValue, mdrValue, inPortValue, yValue};

	// one-hot to index, the highest set bit wins if the rule is broken
	always_comb begin
		srcIndex = '0;
		srcValid = 1'b0;
		for (int i = 0; i < busSourceCount; i++) begin
			if (selBits[i]) begin
				srcIndex = busSelWidth'(i);
				srcValid = 1'b1;
			end
		end
	end

	assign bus = srcValid ? sources[srcIndex] : '0; // idle bus reads zero

	// only one source may drive the shared bus in any cycle
	assert property (@(posedge Clock) disable iff (reset) $onehot0(selBits))
		else $error("busMux: several bus sources selected, outSel = %h", selBits);

endmodule

// ==== hw/dataPath.sv ====
`timescale 1ns/10ps

module dataPath import dataPathPkg::*; (
	input logic Clock,
	input logic reset,
	input outStrobesT outSel,
	input inStrobesT loadSel,
	input aluOpT op,
	input wordT mDataIn,
	input wordT inPortData,
	output wordT busOut
);

	wordT bus; // the shared bus, fed back to every block
	wordT [regCount-1:0] regValues;
	wordT pcValue;
	wordT hiValue;
	wordT loValue;
	wordT inPortValue;
	wordT mdrValue;
	wordT yValue;
	wordT zHighValue;
	wordT zLowValue;

	busMux busMux_i (
		.Clock(Clock),
		.reset(reset),
		.outSel(outSel),
		.regValues(regValues),
		.hiValue(hiValue),
		.loValue(loValue),
		.zHighValue(zHighValue),
		.zLowValue(zLowValue),
		.pcValue(pcValue),
		.mdrValue(mdrValue),
		.inPortValue(inPortValue),
		.yValue(yValue),
		.bus(bus)
	);

	registerFile registerFile_i (
		.Clock(Clock),
		.reset(reset),
		.regIn(loadSel.regIn),
		.bus(bus),
		.regValues(regValues)
	);

	specialRegisters specialRegisters_i (
		.Clock(Clock),
		.reset(reset),
		.loadSel(loadSel),
		.bus(bus),
		.mDataIn(mDataIn),
		.inPortData(inPortData),
		.pcValue(pcValue),
		.hiValue(hiValue),
		.loValue(loValue),
		.inPortValue(inPortValue),
		.mdrValue(mdrValue)
	);

	aluStage aluStage_i (
		.Clock(Clock),
		.reset(reset),
		.yIn(loadSel.yIn),
		.zIn(loadSel.zIn),
		.op(op),
		.bus(bus),
		.yValue(yValue),
		.zHighValue(zHighValue),
		.zLowValue(zLowValue)
	);

	assign busOut = bus;

endmodule

// ==== hw/dataPathPkg.sv ====
package dataPathPkg;

	localparam int wordWidth = 32;
	localparam int regCount = 16; // general registers R0 to R15
	localparam int shiftWidth = 5; // enough for any distance in a word
	localparam int busSourceCount = 24; // sixteen registers plus eight specials
	localparam int busSelWidth = $clog2(busSourceCount);

	typedef logic [wordWidth-1:0] wordT;
	typedef logic [regCount-1:0] regMaskT; // one bit per general register
	typedef logic [shiftWidth-1:0] shiftAmountT;

	// codes follow the control unit encoding, shl is 4
	typedef enum logic [4:0] {
		opAdd = 5'd0,
		opSub = 5'd1,
		opAnd = 5'd2,
		opOr = 5'd3,
		opShl = 5'd4,
		opShr = 5'd5,
		opShra = 5'd6,
		opRor = 5'd7,
		opRol = 5'd8,
		opNeg = 5'd9,
		opNot = 5'd10
	} aluOpT;

	// bit order matches the bus multiplexer source order, yOut is bit 0
	typedef struct packed {
		regMaskT regOut;
		logic hiOut;
		logic loOut;
		logic zHighOut;
		logic zLowOut;
		logic pcOut;
		logic mdrOut;
		logic inPortOut;
		logic yOut;
	} outStrobesT;

	typedef struct packed {
		regMaskT regIn;
		logic hiIn;
		logic loIn;
		logic zIn; // loads both halves of Z
		logic pcIn;
		logic incPc;
		logic mdrIn;
		logic inPortIn;
		logic yIn;
		logic read; // MDR takes the memory word instead of the bus
	} inStrobesT;

endpackage

// ==== hw/registerFile.sv ====
`timescale 1ns/10ps

module registerFile import dataPathPkg::*; (
	input logic Clock,
	input logic reset,
	input regMaskT regIn,
	input wordT bus,
	output wordT [regCount-1:0] regValues
);

	wordT [regCount-1:0] regs;

	// every register with its strobe set takes the same bus word
	always_ff @(posedge Clock) begin
		if (reset) begin
			regs <= '0;
		end else begin
			for (int i = 0; i < regCount; i++) begin
				if (regIn[i]) begin
					regs[i] <= bus;
				end
			end
		end
	end

	assign regValues = regs;

endmodule

// ==== hw/specialRegisters.sv ====
`timescale 1ns/10ps

module specialRegisters import dataPathPkg::*; (
	input logic Clock,
	input logic reset,
	input inStrobesT loadSel,
	input wordT bus,
	input wordT mDataIn,
	input wordT inPortData,
	output wordT pcValue,
	output wordT hiValue,
	output wordT loValue,
	output wordT inPortValue,
	output wordT mdrValue
);

	wordT pc;
	wordT hi;
	wordT lo;
	wordT inPort;
	wordT mdr;
	wordT mdrNext; // memory word or bus

	assign mdrNext = loadSel.read ? mDataIn : bus;

	always_ff @(posedge Clock) begin
		if (reset) begin
			pc <= '0;
			hi <= '0;
			lo <= '0;
			inPort <= '0;
			mdr <= '0;
		end else begin
			if (loadSel.pcIn) begin
				pc <= bus; // a jump target beats the increment
			end else if (loadSel.incPc) begin
				pc <= pc + wordT'(1);
			end
			if (loadSel.hiIn) hi <= bus;
			if (loadSel.loIn) lo <= bus;
			if (loadSel.inPortIn) inPort <= inPortData;
			if (loadSel.mdrIn) mdr <= mdrNext;
		end
	end

	assign pcValue = pc;
	assign hiValue = hi;
	assign loValue = lo;
	assign inPortValue = inPort;
	assign mdrValue = mdr;

	// the control unit must never ask for both PC updates at once
	assert property (@(posedge Clock) disable iff (reset)
		!(loadSel.pcIn && loadSel.incPc))
		else $error("specialRegisters: pcIn and incPc both set");

endmodule

// ==== testbench/dataPathTb.sv ====
`timescale 1ns/10ps

module dataPathTb import dataPathPkg::*; ();

	localparam int clockPeriod = 8;
	localparam int driveDelay = 1; // after the rising edge
	localparam int sampleDelay = 5; // after driving, still before the next edge
	localparam int maxLines = 64;
	localparam int aluOpCount = int'(opNot) + 1;
	localparam int aluRounds = 3;
	localparam int cyclesPerOp = 7;
	localparam int randomCycles = aluRounds * aluOpCount * cyclesPerOp;

	logic Clock;
	logic reset;
	outStrobesT outSel;
	inStrobesT loadSel;
	aluOpT op;
	wordT mDataIn;
	wordT inPortData;
	wordT busOut;

	// one entry per stimulus line
	string lineName [maxLines];
	logic [31:0] lineOut [maxLines];
	logic [31:0] lineIn [maxLines];
	int lineOp [maxLines];
	wordT lineMem [maxLines];
	wordT linePort [maxLines];
	int lineCheck [maxLines];
	wordT lineExpect [maxLines];
	int lineCount = 0;
	int errorCount = 0;
	int checkCount = 0;
	logic stimulusReady = 1'b0;

	dataPath dut_i (
		.Clock(Clock),
		.reset(reset),
		.outSel(outSel),
		.loadSel(loadSel),
		.op(op),
		.mDataIn(mDataIn),
		.inPortData(inPortData),
		.busOut(busOut)
	);

	initial begin
		Clock = 1'b0;
		forever #(clockPeriod / 2) Clock = ~Clock;
	end

	// reference ALU built from the operation rules, rotates bit by bit
	function automatic wordT aluModel(input aluOpT opCode, input wordT a, input wordT b);
		wordT r;
		shiftAmountT s;
		logic [63:0] signExt;
		s = b[4:0];
		r = a;
		signExt = {{32{a[31]}}, a};
		case (opCode)
			opAdd: r = a + b;
			opSub: r = a - b;
			opAnd: r = a & b;
			opOr: r = a | b;
			opShl: r = a << s;
			opShr: r = a >> s;
			opShra: r = wordT'(signExt >> s);
			opRor: for (int i = 0; i < s; i++) r = {r[0], r[31:1]};
			opRol: for (int i = 0; i < s; i++) r = {r[30:0], r[31]};
			opNeg: r = ~b + wordT'(1);
			opNot: r = ~b;
			default: r = '0;
		endcase
		return r;
	endfunction

	task automatic loadStimulus();
		int fd;
		int fields;
		string line;
		string nameStr;
		logic [31:0] outVal;
		logic [31:0] inVal;
		int opVal;
		logic [31:0] memVal;
		logic [31:0] portVal;
		int chkVal;
		logic [31:0] expVal;
		fd = $fopen("testbench/dataPathTestdata.txt", "r");
		if (fd == 0) begin
			$display("could not open the stimulus file testbench/dataPathTestdata.txt");
			errorCount++;
			return;
		end
		while ($fgets(line, fd) != 0) begin
			if (line.len() < 2 || line.getc(0) == "#") continue; // blank or comment
			fields = $sscanf(line, "%s %h %h %d %h %h %d %h", nameStr, outVal, inVal,
				opVal, memVal, portVal, chkVal, expVal);
			if (fields != 8) begin
				$display("malformed stimulus line, expected 8 fields: %s", line);
				errorCount++;
			end else if (lineCount == maxLines) begin
				$display("stimulus file has more than %0d lines, the rest is ignored", maxLines);
				errorCount++;
				break;
			end else begin
				lineName[lineCount] = nameStr;
				lineOut[lineCount] = outVal;
				lineIn[lineCount] = inVal;
				lineOp[lineCount] = opVal;
				lineMem[lineCount] = memVal;
				linePort[lineCount] = portVal;
				lineCheck[lineCount] = chkVal;
				lineExpect[lineCount] = expVal;
				lineCount++;
			end
		end
		$fclose(fd);
	endtask

	// one clock cycle: drive after the edge, sample the bus before the next one
	task automatic runCycle(input string name, input outStrobesT outBits,
		input inStrobesT inBits, input aluOpT opCode, input wordT memWord,
		input wordT portWord, input logic check, input wordT expected);
		@(posedge Clock);
		#driveDelay;
		outSel = outBits;
		loadSel = inBits;
		op = opCode;
		mDataIn = memWord;
		inPortData = portWord;
		#sampleDelay;
		if (check) begin
			checkCount++;
			if (busOut !== expected) begin
				$display("ERROR %s: expected %h, actual %h", name, expected, busOut);
				errorCount++;
			end
		end
	endtask

	// A into Y and back, B with zIn, then both Z halves and Z copied through MDR
	task automatic checkAluOp(input aluOpT opCode, input wordT a, input wordT b);
		outStrobesT srcMdr;
		outStrobesT srcY;
		outStrobesT srcZLow;
		outStrobesT srcZHigh;
		inStrobesT memRead;
		inStrobesT busToMdr;
		inStrobesT loadY;
		inStrobesT loadZ;
		string name;
		wordT expected;
		srcMdr = '0;
		srcMdr.mdrOut = 1'b1;
		srcY = '0;
		srcY.yOut = 1'b1;
		srcZLow = '0;
		srcZLow.zLowOut = 1'b1;
		srcZHigh = '0;
		srcZHigh.zHighOut = 1'b1;
		memRead = '0;
		memRead.mdrIn = 1'b1;
		memRead.read = 1'b1;
		busToMdr = '0;
		busToMdr.mdrIn = 1'b1;
		loadY = '0;
		loadY.yIn = 1'b1;
		loadZ = '0;
		loadZ.zIn = 1'b1;
		name = $sformatf("alu_%s", opCode.name());
		expected = aluModel(opCode, a, b);
		runCycle(name, '0, memRead, opAdd, a, inPortData, 1'b0, '0);
		runCycle(name, srcMdr, loadY, opAdd, a, inPortData, 1'b1, a);
		runCycle(name, srcY, memRead, opAdd, b, inPortData, 1'b1, a);
		runCycle(name, srcMdr, loadZ, opCode, b, inPortData, 1'b1, b);
		runCycle(name, srcZLow, busToMdr, opAdd, b, inPortData, 1'b1, expected);
		runCycle(name, srcZHigh, '0, opAdd, b, inPortData, 1'b1, '0);
		runCycle(name, srcMdr, '0, opAdd, b, inPortData, 1'b1, expected);
	endtask

	initial begin
		int seedInit;
		wordT a;
		wordT b;
		reset = 1'b1;
		outSel = '0;
		loadSel = '0;
		op = opAdd;
		mDataIn = '0;
		inPortData = '0;
		seedInit = $urandom(32'h4e4b);
		loadStimulus();
		stimulusReady = 1'b1;
		repeat (2) @(posedge Clock);
		#driveDelay;
		reset = 1'b0;
		for (int i = 0; i < lineCount; i++) begin
			runCycle(lineName[i], lineOut[i][busSourceCount-1:0], lineIn[i][24:0],
				aluOpT'(lineOp[i]), lineMem[i], linePort[i], lineCheck[i] != 0,
				lineExpect[i]);
		end
		for (int r = 0; r < aluRounds; r++) begin
			for (int k = 0; k < aluOpCount; k++) begin
				a = $urandom();
				b = $urandom();
				checkAluOp(aluOpT'(k), a, b);
			end
		end
		$display("summary: %0d errors in %0d checks", errorCount, checkCount);
		if (errorCount == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// twice the expected length of reset, file lines and random ALU cycles
	initial begin
		wait (stimulusReady);
		#((lineCount + randomCycles + 2) * clockPeriod * 2);
		$display("timeout: the run did not finish in the expected number of cycles");
		$display("Some tests failed");
		$finish;
	end

endmodule

// ==== testbench/dataPathTestdata.txt ====
# name outStrobes(hex,24b) inStrobes(hex,25b) opcode(dec) mDataIn(hex) inPortData(hex)
# check(0/1) expectedBus(hex)
idleBus 000000 0000000 0 00000000 00000000 1 00000000
resetR5 002000 0000000 0 00000000 00000000 1 00000000
resetPc 000008 0000000 0 00000000 00000000 1 00000000
resetZLow 000010 0000000 0 00000000 00000000 1 00000000
mdrRead 000000 0000009 0 deadbeef 00000000 1 00000000
mdrToR3 000004 0001000 0 deadbeef 00000000 1 deadbeef
r3Read 000800 0000000 0 00000000 00000000 1 deadbeef
r3ToR7 000800 0010000 0 00000000 00000000 1 deadbeef
r7Read 008000 0000000 0 00000000 00000000 1 deadbeef
shlMdr12 000000 0000009 0 0000000c 00000000 0 00000000
shlMdrToY 000004 0000002 0 0000000c 00000000 1 0000000c
shlMdr5 000000 0000009 0 00000005 00000000 0 00000000
shlMdrToR2 000004 0000800 0 00000005 00000000 1 00000005
shlR2ToZ 000400 0000040 4 00000000 00000000 1 00000005
shlZLow 000010 0000000 0 00000000 00000000 1 00000180
shlZHigh 000020 0000000 0 00000000 00000000 1 00000000
pcMdr 000000 0000009 0 00001000 00000000 0 00000000
pcLoad 000004 0000020 0 00001000 00000000 1 00001000
pcInc1 000008 0000010 0 00000000 00000000 1 00001000
pcInc2 000008 0000010 0 00000000 00000000 1 00001001
pcRead 000008 0000000 0 00000000 00000000 1 00001002
hiMdr 000000 0000009 0 12345678 00000000 0 00000000
hiLoad 000004 0000100 0 12345678 00000000 1 12345678
loMdr 000000 0000009 0 a5a5a5a5 00000000 0 00000000
loLoad 000004 0000080 0 a5a5a5a5 00000000 1 a5a5a5a5
hiRead 000080 0000000 0 00000000 00000000 1 12345678
loRead 000040 0000000 0 00000000 00000000 1 a5a5a5a5
inPortLoad 000000 0000004 0 00000000 cafef00d 1 00000000
inPortRead 000002 0000000 0 00000000 00000000 1 cafef00d
hiToR0R1 000080 0000600 0 00000000 00000000 1 12345678
r3Keep 000800 0000000 0 00000000 00000000 1 deadbeef
r0Read 000100 0000000 0 00000000 00000000 1 12345678
r1Read 000200 0000000 0 00000000 00000000 1 12345678
r7Keep 008000 0000000 0 00000000 00000000 1 deadbeef
r2Keep 000400 0000000 0 00000000 00000000 1 00000005
